//--- verilog/tx_cfg_pkg.sv
package tx_cfg_pkg;

   // Settings bus map for the TX DSP core
   localparam logic [7:0] DSP_CORE_TX_BASE = 8'd128;
   localparam logic [7:0] TX_CLEAR_ADDR    = DSP_CORE_TX_BASE + 8'd3;  // Write flushes datapath
   localparam logic [7:0] TX_INTERP_ADDR   = DSP_CORE_TX_BASE + 8'd4;  // Interpolation rate

   localparam int TIME_W = 32;   // Master time and send time
   localparam int DATA_W = 32;   // One sample with I and Q packed

   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

endpackage

//--- verilog/tx_pkt_pkg.sv
package tx_pkt_pkg;

   // Buffer pool flag order with occ on top and sop at bit 0
   typedef struct packed {
      logic [1:0] occ;
      logic       eop;
      logic       sop;
   } buf_flags_t;

   typedef struct packed {
      logic [tx_cfg_pkg::DATA_W-1:0] dat;
      buf_flags_t                    flags;
   } buf_word_t;

   // Packet header held until the issue side needs it
   typedef struct packed {
      logic                          send_imm;
      logic                          sob;
      logic                          eob;
      logic [tx_cfg_pkg::TIME_W-1:0] sendtime;
   } ctrl_entry_t;

   typedef struct packed {
      logic                          eop;
      logic [tx_cfg_pkg::DATA_W-1:0] data;
   } sample_entry_t;

   typedef struct packed {
      logic [15:0] occupied;
      logic        full;
      logic        empty;
   } fifo_status_t;

endpackage

//--- verilog/setting_reg.sv
module setting_reg
   #(parameter logic [7:0] my_addr = 8'd0)
   (input  logic                 clk,
    input  logic                 rst,
    input  tx_cfg_pkg::set_bus_t set_i,
    output logic [31:0]          out_o,
    output logic                 changed_o);

   logic hit;

   assign hit = set_i.stb & (set_i.addr == my_addr);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         out_o     <= '0;
         changed_o <= 1'b0;
      end
      else
      begin
         changed_o <= hit;   // One cycle per write
         if (hit)
            out_o <= set_i.data;
      end
   end

endmodule

//--- verilog/sync_fifo.sv
module sync_fifo
   #(parameter int WIDTH      = 32,
     parameter int DEPTH_LOG2 = 4)
   (input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear_i,
    input  logic                     write_i,
    input  logic                     read_i,
    input  logic [WIDTH-1:0]         data_i,
    output logic [WIDTH-1:0]         data_o,
    output tx_pkt_pkg::fifo_status_t status_o);

   localparam int DEPTH = 2**DEPTH_LOG2;

   logic [WIDTH-1:0]      mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic                  full;
   logic                  empty;
   logic                  do_write;
   logic                  do_read;

   assign full  = count[DEPTH_LOG2];   // Count reaches DEPTH only when full
   assign empty = (count == '0);

   // Writes to a full FIFO and reads from an empty one are dropped
   assign do_write = write_i & ~full;
   assign do_read  = read_i & ~empty;

   always_ff @(posedge clk)
   begin
      if (do_write)
         mem[wr_ptr] <= data_i;
   end

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_write)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_read)
            rd_ptr <= rd_ptr + 1'b1;

         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // Head entry falls through
   assign data_o = mem[rd_ptr];

   assign status_o.occupied = 16'(count);
   assign status_o.full     = full;
   assign status_o.empty    = empty;

endmodule

//--- verilog/tx_strobe_gen.sv
module tx_strobe_gen
   (input  logic       clk,
    input  logic       rst,
    input  logic       run_i,
    input  logic [7:0] rate_i,
    output logic       strobe_o);

   logic [7:0] count;
   logic       wrap;

   assign wrap = (count == rate_i);

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         count    <= '0;
         strobe_o <= 1'b0;
      end
      else if (!run_i)
      begin
         count    <= '0;   // Idle between bursts
         strobe_o <= 1'b0;
      end
      else
      begin
         count    <= wrap ? 8'd0 : count + 8'd1;
         strobe_o <= wrap;   // First pulse lands rate+1 after run
      end
   end

endmodule

//--- verilog/tx_control.sv
module tx_control
   #(parameter int SAMPLE_FIFO_LOG2 = 10,
     parameter int CTRL_FIFO_LOG2   = 4)
   (input  logic                          clk,
    input  logic                          rst,
    input  logic                          clear_i,
    input  logic [tx_cfg_pkg::TIME_W-1:0] master_time_i,
    input  tx_pkt_pkg::buf_word_t         buf_i,
    input  logic                          rd_ready_i,
    output logic                          rd_ready_o,
    output logic [tx_cfg_pkg::DATA_W-1:0] sample_o,
    output logic                          run_o,
    input  logic                          strobe_i,
    output logic                          underrun_o,
    output tx_pkt_pkg::fifo_status_t      fifo_o);

   import tx_cfg_pkg::*;
   import tx_pkt_pkg::*;

   typedef enum logic [1:0] {
      XFER_IDLE,
      XFER_CTRL,
      XFER_PKT
   } xfer_state_t;

   typedef enum logic [2:0] {
      IBS_IDLE,
      IBS_WAIT,
      IBS_RUNNING,
      IBS_CONT_BURST,
      IBS_UNDERRUN
   } ibs_state_t;

   localparam logic [15:0] SMP_LAST  = 16'(2**SAMPLE_FIFO_LOG2 - 1);
   localparam logic [15:0] CTRL_LAST = 16'(2**CTRL_FIFO_LOG2 - 1);

   xfer_state_t   xfer_state;
   ibs_state_t    ibs_state;
   logic          xfer;
   logic [2:0]    held_flags;   // send_imm, sob, eob

   logic          smp_write;
   logic          ctrl_write;
   logic          smp_read;
   logic          ctrl_read;
   sample_entry_t smp_wr_data;
   ctrl_entry_t   ctrl_wr_data;
   sample_entry_t smp_head;
   ctrl_entry_t   ctrl_head;
   fifo_status_t  smp_status;
   fifo_status_t  ctrl_status;
   logic          smp_full;
   logic          ctrl_full;

   logic [TIME_W:0] delta_time;
   logic            too_late;
   logic            go_now;

   assign xfer = rd_ready_i & rd_ready_o;

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
         xfer_state <= XFER_IDLE;
      else if (xfer)
         case (xfer_state)
            XFER_IDLE: xfer_state <= XFER_CTRL;
            XFER_CTRL: xfer_state <= XFER_PKT;   // Send time word
            XFER_PKT:
               if (buf_i.flags.eop)
                  xfer_state <= XFER_IDLE;
            default:   xfer_state <= XFER_IDLE;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (xfer && xfer_state == XFER_IDLE)
         held_flags <= buf_i.dat[2:0];
   end

   // Accepted words land in their FIFO one cycle later
   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
      begin
         smp_write  <= 1'b0;
         ctrl_write <= 1'b0;
      end
      else
      begin
         smp_write  <= xfer & (xfer_state == XFER_PKT);
         ctrl_write <= xfer & (xfer_state == XFER_CTRL);
      end
   end

   always_ff @(posedge clk)
   begin
      smp_wr_data.eop        <= buf_i.flags.eop;
      smp_wr_data.data       <= buf_i.dat;
      ctrl_wr_data.send_imm  <= held_flags[2];
      ctrl_wr_data.sob       <= held_flags[1];
      ctrl_wr_data.eob       <= held_flags[0];
      ctrl_wr_data.sendtime  <= buf_i.dat;
   end

   // Full counts the word still in flight
   assign smp_full  = smp_status.full | (smp_write & (smp_status.occupied == SMP_LAST));
   assign ctrl_full = ctrl_status.full | (ctrl_write & (ctrl_status.occupied == CTRL_LAST));
   assign rd_ready_o = ~smp_full & ~ctrl_full;

   sync_fifo #(.WIDTH($bits(sample_entry_t)), .DEPTH_LOG2(SAMPLE_FIFO_LOG2)) sample_fifo
      (.clk      (clk),
       .rst      (rst),
       .clear_i  (clear_i),
       .write_i  (smp_write),
       .read_i   (smp_read),
       .data_i   (smp_wr_data),
       .data_o   (smp_head),
       .status_o (smp_status));

   sync_fifo #(.WIDTH($bits(ctrl_entry_t)), .DEPTH_LOG2(CTRL_FIFO_LOG2)) ctrl_fifo
      (.clk      (clk),
       .rst      (rst),
       .clear_i  (clear_i),
       .write_i  (ctrl_write),
       .read_i   (ctrl_read),
       .data_i   (ctrl_wr_data),
       .data_o   (ctrl_head),
       .status_o (ctrl_status));

   // Negative difference within half the time range means late
   assign delta_time = {1'b0, ctrl_head.sendtime} - {1'b0, master_time_i};
   assign too_late   = (delta_time[TIME_W:TIME_W-1] == 2'b11);
   assign go_now     = (master_time_i == ctrl_head.sendtime);

   always_ff @(posedge clk)
   begin
      if (rst || clear_i)
         ibs_state <= IBS_IDLE;
      else
         case (ibs_state)
            IBS_IDLE:
               if (!ctrl_status.empty && !smp_status.empty)
                  ibs_state <= IBS_WAIT;
            IBS_WAIT:
               if (ctrl_head.send_imm)
                  ibs_state <= IBS_RUNNING;
               else if (too_late)
                  ibs_state <= IBS_UNDERRUN;
               else if (go_now)
                  ibs_state <= IBS_RUNNING;
            IBS_RUNNING:
               if (strobe_i)
               begin
                  if (smp_status.empty)
                     ibs_state <= IBS_UNDERRUN;
                  else if (smp_head.eop)
                     ibs_state <= ctrl_head.eob ? IBS_IDLE : IBS_CONT_BURST;
               end
            IBS_CONT_BURST:
               if (!ctrl_status.empty)
                  ibs_state <= IBS_RUNNING;
               else if (strobe_i)
                  ibs_state <= IBS_UNDERRUN;   // Next packet too slow
            IBS_UNDERRUN:
               ibs_state <= IBS_UNDERRUN;      // Held until clear
            default:
               ibs_state <= IBS_IDLE;
         endcase
   end

   assign smp_read  = (ibs_state == IBS_RUNNING) & strobe_i & ~smp_status.empty;
   assign ctrl_read = smp_read & smp_head.eop;   // Header retires with last sample

   assign run_o      = (ibs_state == IBS_RUNNING) | (ibs_state == IBS_CONT_BURST);
   assign underrun_o = (ibs_state == IBS_UNDERRUN);
   assign sample_o   = smp_head.data;
   assign fifo_o     = smp_status;

endmodule

//--- verilog/tx_core_top.sv
module tx_core_top
   #(parameter int SAMPLE_FIFO_LOG2 = 10,
     parameter int CTRL_FIFO_LOG2   = 4)
   (input  logic                          clk,
    input  logic                          rst,
    input  tx_cfg_pkg::set_bus_t          set_i,
    input  logic [tx_cfg_pkg::TIME_W-1:0] master_time_i,
    input  tx_pkt_pkg::buf_word_t         buf_i,
    input  logic                          rd_ready_i,
    output logic                          rd_ready_o,
    output logic [tx_cfg_pkg::DATA_W-1:0] tx_sample_o,
    output logic                          tx_strobe_o,
    output logic                          tx_run_o,
    output logic                          underrun_o,
    output tx_pkt_pkg::fifo_status_t      fifo_o);

   import tx_cfg_pkg::*;

   logic        clear_state;
   logic [31:0] interp_word;

   setting_reg #(.my_addr(TX_CLEAR_ADDR)) sr_clear
      (.clk       (clk),
       .rst       (rst),
       .set_i     (set_i),
       .out_o     (),
       .changed_o (clear_state));

   setting_reg #(.my_addr(TX_INTERP_ADDR)) sr_interp
      (.clk       (clk),
       .rst       (rst),
       .set_i     (set_i),
       .out_o     (interp_word),
       .changed_o ());

   tx_control #(.SAMPLE_FIFO_LOG2(SAMPLE_FIFO_LOG2),
                .CTRL_FIFO_LOG2  (CTRL_FIFO_LOG2)) tx_control0
      (.clk           (clk),
       .rst           (rst),
       .clear_i       (clear_state),
       .master_time_i (master_time_i),
       .buf_i         (buf_i),
       .rd_ready_i    (rd_ready_i),
       .rd_ready_o    (rd_ready_o),
       .sample_o      (tx_sample_o),
       .run_o         (tx_run_o),
       .strobe_i      (tx_strobe_o),
       .underrun_o    (underrun_o),
       .fifo_o        (fifo_o));

   // Stand-in for the DSP interpolator
   tx_strobe_gen tx_strobe_gen0
      (.clk      (clk),
       .rst      (rst),
       .run_i    (tx_run_o),
       .rate_i   (interp_word[7:0]),
       .strobe_o (tx_strobe_o));

endmodule

//--- verification/tx_core_tests.svh
`ifndef TX_CORE_TESTS_SVH
`define TX_CORE_TESTS_SVH

task automatic reset_state_check();
   start_test("reset_state");
   check_eq("tx_run_o", 0, tx_run);
   check_eq("underrun_o", 0, underrun);
   check_eq("tx_strobe_o", 0, tx_strobe);
   check_eq("rd_ready_o", 1, dut_ready);
   check_eq("empty", 1, fifo_status.empty);
   check_eq("occupied", 0, fifo_status.occupied);
   finish_test();
endtask

task automatic immediate_packet();
   bit done;
   int extra;
   start_test("immediate_packet");
   fork
      send_packet(1'b1, 1'b1, 1'b1, 32'd0, 0, 6, done);
      collect_samples(0, 6);
   join
   check_eq("packet sent", 1, done);
   wait_run_low();
   extra = 0;
   repeat (10)
   begin
      @(negedge clk);
      if (tx_strobe)
         extra++;
   end
   check_eq("strobes after eob", 0, extra);
   check_eq("empty", 1, fifo_status.empty);
   finish_test();
endtask

task automatic timed_packet();
   logic [31:0] stime;
   bit          done;
   int          waited;
   start_test("timed_packet");
   stime = master_time + 32'd40;
   send_packet(1'b0, 1'b1, 1'b1, stime, 6, 4, done);
   check_eq("packet sent", 1, done);
   waited = 0;
   while (master_time < stime && waited < WAIT_LIMIT)
   begin
      check_eq("tx_run_o before send time", 0, tx_run);
      @(negedge clk);
      waited++;
   end
   check_eq("tx_run_o at send time", 1, tx_run);
   collect_samples(6, 4);
   wait_run_low();
   check_eq("underrun_o", 0, underrun);
   check_eq("empty", 1, fifo_status.empty);
   finish_test();
endtask

task automatic late_packet();
   bit done;
   int strobes;
   start_test("late_packet");
   send_packet(1'b0, 1'b1, 1'b1, master_time - 32'd20, 10, 3, done);
   check_eq("packet sent", 1, done);
   wait_underrun(strobes);
   check_eq("strobes while late", 0, strobes);
   write_setting(TX_CLEAR_ADDR, 32'd0);
   check_eq("underrun_o after clear", 0, underrun);
   check_eq("empty after clear", 1, fifo_status.empty);
   check_eq("occupied after clear", 0, fifo_status.occupied);
   finish_test();
endtask

task automatic burst_packets();
   bit done_a;
   bit done_b;
   int strobes;
   start_test("burst_packets");
   fork
      begin
         send_packet(1'b1, 1'b1, 1'b0, 32'd0, 13, 4, done_a);
         send_packet(1'b0, 1'b0, 1'b1, 32'd0, 17, 4, done_b);
      end
      collect_samples(13, 8);
   join
   check_eq("first packet sent", 1, done_a);
   check_eq("second packet sent", 1, done_b);
   wait_run_low();
   check_eq("underrun_o after burst", 0, underrun);
   // Burst left open with nothing behind it
   send_packet(1'b1, 1'b1, 1'b0, 32'd0, 21, 3, done_a);
   check_eq("open packet sent", 1, done_a);
   collect_samples(21, 3);
   wait_underrun(strobes);
   check_eq("strobes after open burst", 1, strobes);
   write_setting(TX_CLEAR_ADDR, 32'd0);
   check_eq("underrun_o after clear", 0, underrun);
   check_eq("tx_run_o after clear", 0, tx_run);
   finish_test();
endtask

task automatic back_pressure();
   bit done;
   start_test("back_pressure");
   send_packet(1'b0, 1'b1, 1'b1, master_time + 32'd100000, 0, 20, done);
   check_eq("packet stalled", 0, done);
   check_eq("rd_ready_o when full", 0, dut_ready);
   check_eq("full", 1, fifo_status.full);
   check_eq("occupied", 16, fifo_status.occupied);
   write_setting(TX_CLEAR_ADDR, 32'd0);
   check_eq("full after clear", 0, fifo_status.full);
   check_eq("occupied after clear", 0, fifo_status.occupied);
   check_eq("rd_ready_o after clear", 1, dut_ready);
   finish_test();
endtask

`endif

//--- verification/tx_core_tb.sv
module tx_core_tb;

   import tx_cfg_pkg::*;
   import tx_pkt_pkg::*;

   localparam int WAIT_LIMIT = 200;   // Cycles any one wait may take

   logic              clk;
   logic              rst;
   set_bus_t          set_bus;
   logic [TIME_W-1:0] master_time;
   buf_word_t         buf_word;
   logic              buf_ready;
   logic              dut_ready;
   logic [DATA_W-1:0] tx_sample;
   logic              tx_strobe;
   logic              tx_run;
   logic              underrun;
   fifo_status_t      fifo_status;

   logic [DATA_W-1:0] expected [32];
   logic [DATA_W-1:0] received [32];
   int                rx_count;
   string             cur_test;
   int                errors;
   int                test_errors;
   int                tests_run;
   int                tests_failed;

   tx_core_top #(.SAMPLE_FIFO_LOG2(4)) dut0
      (.clk           (clk),
       .rst           (rst),
       .set_i         (set_bus),
       .master_time_i (master_time),
       .buf_i         (buf_word),
       .rd_ready_i    (buf_ready),
       .rd_ready_o    (dut_ready),
       .tx_sample_o   (tx_sample),
       .tx_strobe_o   (tx_strobe),
       .tx_run_o      (tx_run),
       .underrun_o    (underrun),
       .fifo_o        (fifo_status));

   initial
   begin
      clk = 1'b1;
      forever
         #50 clk = ~clk;
   end

   // Reads on the falling edge see the count from the previous cycle
   always @(negedge clk)
      master_time <= master_time + 1'b1;

   task automatic check_eq(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
      assert (exp_val === act_val)
      else
      begin
         $display("ERROR %s %s: expected %0h actual %0h", cur_test, what, exp_val, act_val);
         errors++;
      end
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_bus.stb  = 1'b1;
      set_bus.addr = addr;
      set_bus.data = data;
      @(negedge clk);
      set_bus.stb = 1'b0;
      @(negedge clk);   // Clear pulse has acted by now
   endtask

   // Control word, send time, then samples from the expected table
   task automatic send_packet(input logic imm, input logic sob, input logic eob,
                              input logic [31:0] stime, input int first, input int count,
                              output bit done);
      buf_word_t word;
      int        waited;
      int        i;
      done = 1'b1;
      for (i = 0; i < count + 2 && done; i++)
      begin
         if (i == 0)
            word.dat = {29'd0, imm, sob, eob};
         else if (i == 1)
            word.dat = stime;
         else
            word.dat = expected[first + i - 2];
         word.flags.occ = 2'd0;
         word.flags.sop = (i == 0);
         word.flags.eop = (i == count + 1);
         waited = 0;
         while (!dut_ready && waited < WAIT_LIMIT)
         begin
            buf_ready = 1'b0;
            @(negedge clk);
            waited++;
         end
         if (!dut_ready)
            done = 1'b0;   // Stalled by back-pressure
         else
         begin
            buf_word  = word;
            buf_ready = 1'b1;
            @(negedge clk);
         end
      end
      buf_ready = 1'b0;
   endtask

   task automatic collect_samples(input int first, input int count);
      int waited;
      int i;
      rx_count = 0;
      waited   = 0;
      while (rx_count < count && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         if (tx_strobe)
         begin
            received[rx_count] = tx_sample;
            rx_count++;
            waited = 0;
         end
         else
            waited++;
      end
      assert (rx_count == count)
      else
      begin
         $display("%s: timeout, only %0d of %0d samples came out", cur_test, rx_count, count);
         errors++;
      end
      for (i = 0; i < rx_count; i++)
         check_eq($sformatf("sample %0d", i), expected[first + i], received[i]);
   endtask

   task automatic wait_run_low();
      int waited;
      waited = 0;
      while (tx_run && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      assert (!tx_run)
      else
      begin
         $display("%s: timeout, tx_run_o stayed high", cur_test);
         errors++;
      end
   endtask

   task automatic wait_underrun(output int strobes);
      int waited;
      waited  = 0;
      strobes = 0;
      while (!underrun && waited < WAIT_LIMIT)
      begin
         @(negedge clk);
         if (tx_strobe)
            strobes++;
         waited++;
      end
      assert (underrun)
      else
      begin
         $display("%s: timeout, underrun_o never rose", cur_test);
         errors++;
      end
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = errors;
      tests_run++;
      write_setting(TX_INTERP_ADDR, 32'd3);   // One strobe every 4 cycles
   endtask

   task automatic finish_test();
      if (errors == test_errors)
         $display("%s: passed", cur_test);
      else
      begin
         $display("%s: failed with %0d errors", cur_test, errors - test_errors);
         tests_failed++;
      end
   endtask

`include "tx_core_tests.svh"

   initial
   begin
      int i;
      void'($urandom(45));
      rst          = 1'b1;
      set_bus      = '0;
      master_time  = '0;
      buf_word     = '0;
      buf_ready    = 1'b0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      for (i = 0; i < 32; i++)
         expected[i] = $urandom;
      @(negedge clk);   // Align to the first falling edge
      repeat (8) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      reset_state_check();
      immediate_packet();
      timed_packet();
      late_packet();
      burst_packets();
      back_pressure();
      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

//--- list.f
+incdir+verification
verilog/tx_cfg_pkg.sv
verilog/tx_pkt_pkg.sv
verilog/setting_reg.sv
verilog/sync_fifo.sv
verilog/tx_strobe_gen.sv
verilog/tx_control.sv
verilog/tx_core_top.sv
verification/tx_core_tb.sv
